// File: all.f
+incdir+.
rvIsaPkg.sv
rvCorePkg.sv
instDecode.sv
regFile.sv
intAlu.sv
branchUnit.sv
retireCtrl.sv
rv32Exec.sv
rv32Exec_assertions.sv
tbRv32Exec.sv

// File: branchUnit.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module branchUnit (
    input  rvIsaPkg::decodedT dec,
    input  rvCorePkg::wordT   rs1Data,
    input  rvCorePkg::wordT   rs2Data,
    input  rvCorePkg::wordT   pc,
    output rvCorePkg::wordT   nextPc,
    output rvCorePkg::wordT   linkValue,
    output logic              branchIllegal
);
    import rvIsaPkg::*;
    import rvCorePkg::*;

    logic taken;
    wordT seqPc;        // fall-through address
    wordT jalrSum;

    assign seqPc     = pc + `PC_STEP;
    assign linkValue = seqPc;
    assign jalrSum   = rs1Data + dec.immI;

    always_comb begin
        case (dec.funct3)
            F3_BEQ:  taken = rs1Data == rs2Data;
            F3_BNE:  taken = rs1Data != rs2Data;
            F3_BLT:  taken = $signed(rs1Data) < $signed(rs2Data);
            F3_BGE:  taken = $signed(rs1Data) >= $signed(rs2Data);
            F3_BLTU: taken = rs1Data < rs2Data;
            F3_BGEU: taken = rs1Data >= rs2Data;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.opcode)
            BRANCH:  nextPc = taken ? pc + dec.immSB : seqPc;
            JAL:     nextPc = pc + dec.immUJ;
            JALR:    nextPc = {jalrSum[`XLEN-1:1], 1'b0};   // target is rs1-relative
            default: nextPc = seqPc;
        endcase
    end

    // branch funct3 010 and 011 are unassigned
    assign branchIllegal = ((dec.opcode == BRANCH) && (dec.funct3[2:1] == 2'b01)) ||
                           ((dec.opcode == JALR) && (dec.funct3 != F3_JALR));

endmodule

// File: instDecode.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module instDecode (
    input  rvCorePkg::wordT   instr,
    output rvIsaPkg::decodedT dec
);
    import rvIsaPkg::*;

    always_comb begin
        dec.opcode = opcodeT'(instr[6:0]);
        dec.rd     = instr[11:7];
        dec.funct3 = instr[14:12];
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.funct7 = instr[31:25];

        // I-type, 12 bits from the top
        dec.immI  = {{(`XLEN-12){instr[31]}}, instr[31:20]};

        // SB-type, halfword offset
        dec.immSB = {{(`XLEN-13){instr[31]}},
                     instr[31],
                     instr[7],
                     instr[30:25],
                     instr[11:8],
                     1'b0};

        // U-type, upper 20 bits
        dec.immU  = {instr[31:12], 12'b0};

        // UJ-type, 21-bit jump offset
        dec.immUJ = {{(`XLEN-21){instr[31]}},
                     instr[31],
                     instr[19:12],
                     instr[20],
                     instr[30:21],
                     1'b0};

        case (dec.opcode)
            OP, OP_IMM, LUI, AUIPC, JAL, JALR, BRANCH: begin
                dec.known = 1'b1;
            end
            default: begin
                dec.known = 1'b0;       // loads, stores and the rest
            end
        endcase
    end

endmodule

// File: intAlu.sv
`timescale 1ns/1ns

module intAlu (
    input  rvIsaPkg::decodedT dec,
    input  rvCorePkg::wordT   rs1Data,
    input  rvCorePkg::wordT   rs2Data,
    input  rvCorePkg::wordT   pc,
    output rvCorePkg::wordT   aluResult,
    output logic              aluIllegal
);
    import rvIsaPkg::*;
    import rvCorePkg::*;

    logic       isImm;
    wordT       opB;        // rs2 or immI
    logic [4:0] shamt;
    logic       altOp;      // SUB / SRA select
    logic       ltS;
    logic       ltU;
    wordT       arith;

    assign isImm = (dec.opcode == OP_IMM);
    assign opB   = isImm ? dec.immI : rs2Data;
    assign shamt = opB[4:0];
    assign altOp = isImm ? dec.immI[10] : dec.funct7[5];
    assign ltS   = $signed(rs1Data) < $signed(opB);
    assign ltU   = rs1Data < opB;

    always_comb begin
        case (dec.funct3)
            F3_ADD:  arith = (altOp && !isImm) ? rs1Data - opB : rs1Data + opB;
            F3_SLL:  arith = rs1Data << shamt;
            F3_SLT:  arith = wordT'(ltS);
            F3_SLTU: arith = isImm ? '0 : wordT'(ltU);     // SLTIU not supported
            F3_XOR:  arith = rs1Data ^ opB;
            F3_SR:   arith = altOp ? wordT'($signed(rs1Data) >>> shamt) : rs1Data >> shamt;
            F3_OR:   arith = rs1Data | opB;
            default: arith = rs1Data & opB;                 // AND, ANDI
        endcase
    end

    always_comb begin
        case (dec.opcode)
            OP, OP_IMM: aluResult = arith;
            LUI:        aluResult = dec.immU;
            AUIPC:      aluResult = pc + dec.immU;
            default:    aluResult = '0;     // jumps and branches use linkValue
        endcase
    end

    // illegal funct7 / shift-immediate patterns
    always_comb begin
        aluIllegal = 1'b0;
        if (dec.opcode == OP) begin
            if ((dec.funct3 == F3_ADD) || (dec.funct3 == F3_SR)) begin
                aluIllegal = (dec.funct7 & ~F7_ALT) != F7_ZERO;
            end else begin
                aluIllegal = dec.funct7 != F7_ZERO;
            end
        end else if (isImm) begin
            case (dec.funct3)
                F3_SLTU: aluIllegal = 1'b1;
                F3_SLL:  aluIllegal = dec.immI[11:5] != F7_ZERO;
                F3_SR:   aluIllegal = (dec.immI[11:5] & ~F7_ALT) != F7_ZERO;
                default: aluIllegal = 1'b0;
            endcase
        end
    end

endmodule

// File: regFile.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module regFile (
    input  logic               clk,
    input  logic               rst,
    input  rvCorePkg::regAddrT rdAddrA,
    input  rvCorePkg::regAddrT rdAddrB,
    output rvCorePkg::wordT    rdDataA,
    output rvCorePkg::wordT    rdDataB,
    input  logic               wrEn,
    input  rvCorePkg::regAddrT wrAddr,
    input  rvCorePkg::wordT    wrData
);
    import rvCorePkg::*;

    wordT regs [1:`REG_COUNT-1];    // x1..x31, x0 has no storage

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;     // writes to x0 dropped
        end
    end

    // asynchronous reads
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

// File: retireCtrl.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module retireCtrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  rvCorePkg::wordT    instr,
    output logic               ack,
    output rvCorePkg::wordT    latchedInstr,
    input  rvIsaPkg::decodedT  dec,
    input  rvCorePkg::wordT    aluResult,
    input  rvCorePkg::wordT    nextPc,
    input  rvCorePkg::wordT    linkValue,
    input  logic               aluIllegal,
    input  logic               branchIllegal,
    output rvCorePkg::wordT    pc,
    output logic               wrEn,
    output rvCorePkg::regAddrT wrAddr,
    output rvCorePkg::wordT    wrData,
    output logic               wbEn,
    output rvCorePkg::regAddrT wbAddr,
    output rvCorePkg::wordT    wbData,
    output logic               halted
);
    import rvCorePkg::*;
    import rvIsaPkg::*;

    hsStateT state;
    logic    haltNow;       // instruction in EXEC is not executable
    logic    retire;        // EXEC cycle with a live core
    logic    isJump;

    assign haltNow = !dec.known || aluIllegal || branchIllegal;
    assign retire  = (state == EXEC) && !halted && !haltNow;
    assign isJump  = (dec.opcode == JAL) || (dec.opcode == JALR);

    // register file write lands on the retire edge
    assign wrEn   = retire && (dec.opcode != BRANCH);
    assign wrAddr = dec.rd;
    assign wrData = isJump ? linkValue : aluResult;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state  <= IDLE;
            ack    <= 1'b0;
            wbEn   <= 1'b0;
            halted <= 1'b0;
            pc     <= `RESET_PC;
        end else begin
            wbEn <= 1'b0;       // one-cycle pulse
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    ack   <= 1'b1;
                    wbEn  <= wrEn;
                    state <= ACKED;
                    if (retire) begin
                        pc <= nextPc;
                    end
                    if (haltNow) begin
                        halted <= 1'b1;     // sticky until reset
                    end
                end
                ACKED: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // instruction and write-back payload
    always_ff @(posedge clk) begin
        if ((state == IDLE) && req) begin
            latchedInstr <= instr;
        end
        if (wrEn) begin
            wbAddr <= wrAddr;
            wbData <= wrData;
        end
    end

endmodule

// File: rv32Exec.sv
`timescale 1ns/1ns

module rv32Exec (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  rvCorePkg::wordT    instr,
    output logic               ack,
    output logic               wbEn,
    output rvCorePkg::regAddrT wbAddr,
    output rvCorePkg::wordT    wbData,
    output rvCorePkg::wordT    pc,
    output logic               halted
);
    import rvCorePkg::*;
    import rvIsaPkg::*;

    wordT    latchedInstr;
    decodedT dec;
    wordT    rdDataA;
    wordT    rdDataB;
    wordT    aluResult;
    logic    aluIllegal;
    wordT    nextPc;
    wordT    linkValue;
    logic    branchIllegal;
    logic    wrEn;
    regAddrT wrAddr;
    wordT    wrData;

    retireCtrl retire0 (
        .clk(clk), .rst(rst), .req(req), .instr(instr), .ack(ack),
        .latchedInstr(latchedInstr), .dec(dec),
        .aluResult(aluResult), .nextPc(nextPc), .linkValue(linkValue),
        .aluIllegal(aluIllegal), .branchIllegal(branchIllegal), .pc(pc),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData), .halted(halted)
    );

    instDecode decode0 (.instr(latchedInstr), .dec(dec));

    regFile regs0 (
        .clk(clk), .rst(rst),
        .rdAddrA(dec.rs1), .rdAddrB(dec.rs2), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
    );

    intAlu alu0 (
        .dec(dec), .rs1Data(rdDataA), .rs2Data(rdDataB), .pc(pc),
        .aluResult(aluResult), .aluIllegal(aluIllegal)
    );

    branchUnit branch0 (
        .dec(dec), .rs1Data(rdDataA), .rs2Data(rdDataB), .pc(pc),
        .nextPc(nextPc), .linkValue(linkValue), .branchIllegal(branchIllegal)
    );

endmodule

// File: rv32Exec_assertions.sv
`timescale 1ns/1ns

module rv32ExecAssertions (
    input logic               clk,
    input logic               rst,
    input logic               req,
    input logic               ack,
    input logic               wbEn,
    input logic               halted,
    input rvCorePkg::hsStateT state
);
    import rvCorePkg::*;

    // ack holds through ACKED until req is seen low
    ackHeld: assert property (@(posedge clk) disable iff (!rst)
        (state == ACKED) && req |=> ack)
        else $error("ack fell while req was still high");

    wbOnRetire: assert property (@(posedge clk) disable iff (!rst) wbEn |-> $rose(ack))
        else $error("wbEn high outside the cycle in which ack rose");

    haltSticky: assert property (@(posedge clk) halted && rst |=> halted)
        else $error("halted cleared without reset");     // sticky flag

endmodule

bind retireCtrl rv32ExecAssertions checks0 (
    .clk(clk), .rst(rst), .req(req), .ack(ack), .wbEn(wbEn), .halted(halted), .state(state)
);

// File: rvCorePkg.sv
package rvCorePkg;

`include "rv_macros.svh"

    // datapath word, also used for the PC
    typedef logic [`XLEN-1:0] wordT;

    // register index
    typedef logic [$clog2(`REG_COUNT)-1:0] regAddrT;

    // req/ack phases of one instruction
    typedef enum logic [1:0] {
        IDLE  = 2'd0,       // waiting for req
        EXEC  = 2'd1,       // instruction latched, retires next edge
        ACKED = 2'd2        // ack high until req drops
    } hsStateT;

endpackage

// File: rvIsaPkg.sv
package rvIsaPkg;

`include "rv_macros.svh"

    typedef enum logic [6:0] {
        OP     = 7'b0110011,        // register-register arithmetic
        OP_IMM = 7'b0010011,        // immediate arithmetic
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } opcodeT;

    typedef logic [2:0] funct3T;

    // arithmetic funct3, shared by OP and OP_IMM
    localparam funct3T F3_ADD  = 3'b000;
    localparam funct3T F3_SLL  = 3'b001;
    localparam funct3T F3_SLT  = 3'b010;
    localparam funct3T F3_SLTU = 3'b011;     // no immediate form here
    localparam funct3T F3_XOR  = 3'b100;
    localparam funct3T F3_SR   = 3'b101;     // SRL/SRA by funct7 bit 5
    localparam funct3T F3_OR   = 3'b110;
    localparam funct3T F3_AND  = 3'b111;

    // branch conditions
    localparam funct3T F3_BEQ  = 3'b000;
    localparam funct3T F3_BNE  = 3'b001;
    localparam funct3T F3_BLT  = 3'b100;
    localparam funct3T F3_BGE  = 3'b101;
    localparam funct3T F3_BLTU = 3'b110;
    localparam funct3T F3_BGEU = 3'b111;
    localparam funct3T F3_JALR = 3'b000;

    localparam logic [6:0] F7_ZERO = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;    // SUB and SRA

    typedef struct packed {
        opcodeT            opcode;
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        funct3T            funct3;
        logic [6:0]        funct7;
        logic [`XLEN-1:0]  immI;
        logic [`XLEN-1:0]  immSB;
        logic [`XLEN-1:0]  immU;
        logic [`XLEN-1:0]  immUJ;
        logic              known;       // one of the seven kept opcodes
    } decodedT;

endpackage

// File: rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// machine word and program counter width
`define XLEN 32

// architectural integer registers, x0 included
`define REG_COUNT 32

// byte distance between sequential instructions
`define PC_STEP 32'd4

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

// File: tbRv32Exec.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module tbRv32Exec;
    import rvIsaPkg::*;

    localparam int SEGMENTS    = 6;     // each segment ends in another illegal class
    localparam int LEGAL_RUN   = 60;
    localparam int PER_SEGMENT = LEGAL_RUN + 10;
    localparam int CYCLE_LIMIT = 6 * SEGMENTS * PER_SEGMENT + 100;

    logic        clk, rst, req, ack, wbEn, halted;
    logic [31:0] instr, wbData, pc;
    logic [4:0]  wbAddr;
    logic [31:0] rngState;
    logic [31:0] mRegs [0:31];          // reference register file
    logic [31:0] mPc;
    logic        mHalted;
    int          valueErrors, protocolErrors, cycles;

    rv32Exec dut (
        .clk(clk), .rst(rst), .req(req), .instr(instr), .ack(ack), .wbEn(wbEn),
        .wbAddr(wbAddr), .wbData(wbData), .pc(pc), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] nextRandom();
        logic [31:0] s;
        s = rngState;
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        rngState = s;
        return s;
    endfunction

    // weighted opcode classes with random legal fields
    function automatic logic [31:0] legalInstr();
        logic [31:0] r;
        logic [31:0] ins;
        r = nextRandom();
        ins = nextRandom() & 32'hFFF7_F7FF;     // rd and rs1 in x0..x15
        case (r % 10)
            0, 1, 2: begin
                ins[31:25] = ((ins[14:12] == 3'b000 || ins[14:12] == 3'b101) && r[20]) ?
                             7'h20 : 7'h00;
                ins[6:0] = OP;
            end
            3, 4, 5: begin
                if (ins[14:12] == 3'b011) ins[14:12] = 3'b000;      // no SLTIU
                if (ins[13:12] == 2'b01) ins[31:25] = {1'b0, ins[14] & r[20], 5'b0};
                ins[6:0] = OP_IMM;
            end
            6: ins[6:0] = r[20] ? LUI : AUIPC;
            7: ins = {ins[31:15], 3'b000, ins[11:7], (r[20] ? JAL : JALR)};
            default: ins = {ins[31:14], ins[14] & ins[13], ins[12:7], BRANCH};
        endcase
        return ins;
    endfunction

    function automatic logic [31:0] illegalInstr(int kind);
        logic [31:0] ins;
        ins = nextRandom();
        case (kind)
            0: ins = (ins & ~32'h7F) | 32'h0200_0033;       // R-type funct7 bit 0
            1: ins = (ins & ~32'h707F) | 32'h0000_3013;     // SLTIU
            2: ins = (ins & ~32'h307F) | 32'h0400_1013;     // shift with upper imm bit set
            3: ins = (ins & ~32'h607F) | 32'h0000_2063;     // branch funct3 01x
            4: ins = (ins & ~32'h7F) | 32'h0000_1067;       // JALR funct3 nonzero
            default: ins = (ins & ~32'h7F) | (ins[31] ? 32'h03 : 32'h23);  // load or store
        endcase
        return ins;
    endfunction

    task automatic modelRetire(input logic [31:0] ins, output logic expWrite,
                               output logic [31:0] expData);
        logic [31:0] a, b, immI, target;
        logic        isImm, bad;
        a = mRegs[ins[19:15]];
        immI = {{20{ins[31]}}, ins[31:20]};
        isImm = ins[6:0] == OP_IMM;
        b = isImm ? immI : mRegs[ins[24:20]];
        expWrite = 1'b1;
        expData = 32'h0;
        target = mPc + `PC_STEP;
        bad = 1'b0;
        case (ins[6:0])
            OP, OP_IMM: begin
                case (ins[14:12])
                    3'b000: expData = (ins[30] && !isImm) ? a - b : a + b;
                    3'b001: expData = a << b[4:0];
                    3'b010: expData = {31'b0, $signed(a) < $signed(b)};
                    3'b011: expData = {31'b0, a < b};
                    3'b100: expData = a ^ b;
                    3'b101: expData = (a >> b[4:0]) |
                                      ((ins[30] && a[31]) ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'h0);
                    3'b110: expData = a | b;
                    default: expData = a & b;
                endcase
                if (isImm) begin
                    bad = ins[14:12] == 3'b011 ||
                          (ins[13:12] == 2'b01 && (ins[31:25] & (ins[14] ? 7'h5F : 7'h7F)) != 0);
                end else begin
                    bad = (ins[31:25] & ((ins[14:12] == 3'b000 || ins[14:12] == 3'b101) ?
                                         7'h5F : 7'h7F)) != 0;
                end
            end
            LUI:   expData = {ins[31:12], 12'h000};
            AUIPC: expData = mPc + {ins[31:12], 12'h000};
            JAL: begin
                expData = mPc + `PC_STEP;
                target = mPc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            JALR: begin
                expData = mPc + `PC_STEP;
                target = (a + immI) & ~32'h1;
                bad = ins[14:12] != 3'b000;
            end
            BRANCH: begin
                expWrite = 1'b0;
                bad = ins[14:13] == 2'b01;
                // bit 12 inverts the eq / lt / ltu result
                if (ins[12] ^ (ins[14] ? (ins[13] ? a < b : $signed(a) < $signed(b)) : a == b))
                    target = mPc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            default: bad = 1'b1;    // unknown, load and store opcodes
        endcase
        if (mHalted || bad) begin
            mHalted = 1'b1;
            expWrite = 1'b0;
        end else begin
            mPc = target;
            if (expWrite && ins[11:7] != 5'd0) mRegs[ins[11:7]] = expData;
        end
    endtask

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic resetCore();
        rst = 1'b0;
        req = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
        for (int i = 0; i < 32; i++) mRegs[i] = 32'h0;
        mPc = `RESET_PC;
        mHalted = 1'b0;
        compareValue("pc", pc, `RESET_PC);
        if (ack || wbEn || halted) begin
            $display("ack, wbEn or halted still high after reset");
            protocolErrors++;
        end
    endtask

    // one req/ack exchange entered 1 ns after a rising edge
    task automatic runInstr(input logic [31:0] ins);
        logic        expWrite;
        logic [31:0] expData;
        int          edges;
        int          pulses;
        modelRetire(ins, expWrite, expData);
        req = 1'b1;
        instr = ins;
        edges = 0;
        pulses = 0;
        while (!ack && edges < 10) begin
            @(posedge clk);
            #1;
            edges++;
            pulses += wbEn;
        end
        if (edges != 2) begin
            $display("ack seen %0d edges after req instead of 2", edges);
            protocolErrors++;
        end
        compareValue("wbEn", {31'b0, wbEn}, {31'b0, expWrite});
        if (expWrite) begin
            compareValue("wbAddr", {27'b0, wbAddr}, {27'b0, ins[11:7]});
            compareValue("wbData", wbData, expData);
        end
        repeat (nextRandom() % 3) begin     // back-pressure
            @(posedge clk);
            #1;
            pulses += wbEn;
            if (!ack) begin
                $display("ack dropped while req was held high");
                protocolErrors++;
            end
        end
        req = 1'b0;
        @(posedge clk);
        #1;
        pulses += wbEn;
        if (ack || pulses != int'(expWrite)) begin
            $display("ack not low one edge after req fell, or wrong number of wbEn pulses");
            protocolErrors++;
        end
        compareValue("pc", pc, mPc);
        compareValue("halted", {31'b0, halted}, {31'b0, mHalted});
    endtask

    initial begin
        rngState = 89;
        valueErrors = 0;
        protocolErrors = 0;
        rst = 1'b0;
        req = 1'b0;
        instr = 32'h0;
        for (int seg = 0; seg < SEGMENTS; seg++) begin
            resetCore();
            for (int n = 0; n < PER_SEGMENT; n++) begin
                runInstr(n == LEGAL_RUN ? illegalInstr(seg) : legalInstr());
            end
        end
        $display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
